/* src.f */
source/rv_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/register_file.sv
source/alu.sv
source/load_store_unit.sv
source/rv_core.sv
sim/rv_core_properties.sv
sim/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f src.f
./obj_dir/Vtb_rv_core | tee sim.log

if grep -qF "** FAIL **" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam int imem_words     = 64;
  localparam int dmem_words     = 32;
  localparam int iaw            = $clog2(imem_words);
  localparam int daw            = $clog2(dmem_words);
  localparam int prog_len       = 40;
  localparam int num_progs      = 8;
  localparam int run_cycles     = 200;
  localparam int reset_cycles   = 5;
  localparam int retire_timeout = 8;

  logic            clk = 1'b0;
  logic            reset;
  logic            load_en;
  logic [iaw-1:0]  load_addr;
  logic [31:0]     load_data;
  logic            retire;
  rv_pkg::commit_t commit;

  logic [31:0] lfsr;
  logic [31:0] prog [imem_words];
  logic [31:0] mregs [32];
  logic [31:0] mmem [dmem_words];
  logic [31:0] mpc;
  int          errors;
  int          checks;
  bit          aborted;

  rv_core #(
    .imem_words(imem_words),
    .dmem_words(dmem_words)
  ) i_rv_core (
    .clk(clk),
    .reset(reset),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .retire(retire),
    .commit(commit)
  );

  always #10 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // nonzero offset of 4 to 16 bytes either way
  function automatic logic [31:0] short_offset();
    int w;
    w = int'(rand_bits(3));
    w = (w < 4) ? w - 4 : w - 3;
    return 32'(w * 4);
  endfunction

  function automatic logic [31:0] gen_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] o;
    rd   = {1'b0, 4'(rand_bits(4))};
    rs1  = {1'b0, 4'(rand_bits(4))};
    rs2  = {1'b0, 4'(rand_bits(4))};
    kind = 4'(rand_bits(4));
    f3   = 3'(rand_bits(3));
    o    = rand_bits(12);
    case (kind)
      4'd0, 4'd1, 4'd2: begin
        // no sltu
        if (f3 == 3'b011) f3 = 3'b010;
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && o[0]) ? 7'h20 : 7'h00;
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
      end
      4'd3, 4'd4, 4'd5: begin
        if (f3 == 3'b010 || f3 == 3'b011) f3 = 3'b000;
        if (f3 == 3'b001) o[11:5] = 7'h00;
        if (f3 == 3'b101) o[11:5] = o[10] ? 7'h20 : 7'h00;
        return {o[11:0], rs1, f3, rd, 7'b0010011};
      end
      4'd6: begin
        o = rand_bits(20);
        return {o[19:0], rd, 7'b0110111};
      end
      4'd7, 4'd8: begin
        o = rand_bits(5) << 2;
        return {o[11:0], 5'd0, 3'b010, rd, 7'b0000011};
      end
      4'd9, 4'd10: begin
        o = rand_bits(5) << 2;
        return {o[11:5], rs2, 5'd0, 3'b010, o[4:0], 7'b0100011};
      end
      4'd11: begin
        o = short_offset();
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
      end
      4'd12: begin
        o = rand_bits(6);
        return {o[11:0], rs1, 3'b000, rd, 7'b1100111};
      end
      4'd13, 4'd14: begin
        o  = short_offset();
        f3 = (kind == 4'd13) ? 3'b000 : 3'b001;
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
      end
      default: begin
        // unsupported auipc or system word
        o = rand_bits(25);
        return {o[24:0], (o[0] ? 7'b0010111 : 7'b1110011)};
      end
    endcase
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
      end
  endtask

  task automatic wait_retire();
    int n;
    n = 0;
    @(negedge clk);
    while (!retire && n < retire_timeout) begin
      @(negedge clk);
      n++;
    end
    if (!retire) begin
      errors++;
      aborted = 1'b1;
      $display("timeout: retire stayed low for %0d cycles", retire_timeout);
    end
  endtask

  // executes the instruction at mpc in the model and checks the commit
  task automatic check_commit();
    rv_pkg::instr_t iw;
    logic [31:0]    w;
    logic [31:0]    a;
    logic [31:0]    b;
    logic [31:0]    imm_i;
    logic [31:0]    imm_s;
    logic [31:0]    imm_b;
    logic [31:0]    imm_j;
    logic [31:0]    res;
    logic [31:0]    addr;
    logic [31:0]    next_pc;
    logic           wr;
    logic           st;
    w       = prog[iaw'(mpc >> 2)];
    iw      = w;
    a       = mregs[iw.r.rs1];
    b       = mregs[iw.r.rs2];
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    wr      = 1'b0;
    st      = 1'b0;
    res     = '0;
    addr    = '0;
    next_pc = mpc + 32'd4;
    case (iw.r.opcode)
      rv_pkg::opc_op: begin
        wr = 1'b1;
        case ({iw.r.funct7, iw.r.funct3})
          10'h000: res = a + b;
          10'h100: res = a - b;
          10'h001: res = a << b[4:0];
          10'h002: res = {31'b0, $signed(a) < $signed(b)};
          10'h004: res = a ^ b;
          10'h005: res = a >> b[4:0];
          10'h105: res = $signed(a) >>> b[4:0];
          10'h006: res = a | b;
          10'h007: res = a & b;
          default: wr = 1'b0;
        endcase
      end
      rv_pkg::opc_op_imm: begin
        wr = 1'b1;
        case (iw.i.funct3)
          3'b000: res = a + imm_i;
          3'b100: res = a ^ imm_i;
          3'b110: res = a | imm_i;
          3'b111: res = a & imm_i;
          3'b001: begin
            res = a << w[24:20];
            wr  = (w[31:25] == 7'h00);
          end
          3'b101: begin
            if (w[30]) res = $signed(a) >>> w[24:20];
            else res = a >> w[24:20];
            wr = (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
          end
          default: wr = 1'b0;
        endcase
      end
      rv_pkg::opc_lui: begin
        wr  = 1'b1;
        res = {w[31:12], 12'b0};
      end
      rv_pkg::opc_load: begin
        wr   = (iw.i.funct3 == 3'b010);
        addr = a + imm_i;
        res  = mmem[daw'(addr >> 2)];
      end
      rv_pkg::opc_store: begin
        st   = (iw.s.funct3 == 3'b010);
        addr = a + imm_s;
      end
      rv_pkg::opc_jal: begin
        wr      = 1'b1;
        res     = mpc + 32'd4;
        next_pc = mpc + imm_j;
      end
      rv_pkg::opc_jalr: begin
        if (iw.i.funct3 == 3'b000) begin
          wr      = 1'b1;
          res     = mpc + 32'd4;
          next_pc = (a + imm_i) & ~32'd1;
        end
      end
      rv_pkg::opc_branch: begin
        if (iw.b.funct3 == 3'b000 && a == b) next_pc = mpc + imm_b;
        if (iw.b.funct3 == 3'b001 && a != b) next_pc = mpc + imm_b;
      end
      default: wr = 1'b0;
    endcase
    wr = wr && (iw.r.rd != 5'd0);

    check_word("commit.pc", commit.pc, mpc);
    check_word("commit.instr", commit.instr, w);
    check_word("commit.rd_we", 32'(commit.rd_we), 32'(wr));
    check_word("commit.st_we", 32'(commit.st_we), 32'(st));
    if (wr) begin
      check_word("commit.rd", 32'(commit.rd), 32'(iw.r.rd));
      check_word("commit.rd_data", commit.rd_data, res);
      mregs[iw.r.rd] = res;
    end
    if (st) begin
      check_word("commit.st_addr", commit.st_addr, addr);
      check_word("commit.st_data", commit.st_data, b);
      mmem[daw'(addr >> 2)] = b;
    end
    mpc = next_pc;
  endtask

  task automatic run_program();
    for (int i = 0; i < imem_words; i++) begin
      if (i < prog_len) prog[i] = gen_instr();
      // filler nop carries its word index in the immediate
      else prog[i] = {12'(i), 20'h00013};
    end
    @(posedge clk);
    reset <= 1'b1;
    for (int i = 0; i < imem_words; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= iaw'(i);
      load_data <= prog[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    // model state after reset
    mpc = '0;
    for (int i = 0; i < 32; i++) mregs[i] = '0;
    for (int i = 0; i < dmem_words; i++) mmem[i] = '0;
    for (int c = 0; c < run_cycles && !aborted; c++) begin
      wait_retire();
      if (!aborted) check_commit();
    end
  endtask

  initial begin
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    lfsr      = 32'd50;
    errors    = 0;
    checks    = 0;
    aborted   = 1'b0;
    for (int p = 0; p < num_progs && !aborted; p++) begin
      run_program();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* sim/rv_core_properties.sv */
`timescale 1ns/1ps

module rv_core_properties (
  input logic            clk,
  input logic            reset,
  input logic            retire,
  input rv_pkg::commit_t commit
);

  // no retirement while held in reset
  retire_low_in_reset: assert property (@(posedge clk) reset |-> !retire)
    else $error("retire is high while reset is asserted");

  no_write_to_x0: assert property (@(posedge clk) disable iff (reset)
    commit.rd_we |-> (commit.rd != 5'd0))
    else $error("rd_we is set with rd equal to zero");

  store_without_write: assert property (@(posedge clk) disable iff (reset)
    commit.st_we |-> !commit.rd_we)
    else $error("a store commit also writes a register");

  // first fetch after reset
  pc_zero_after_reset: assert property (@(posedge clk) $fell(reset) |-> (commit.pc == '0))
    else $error("first pc after reset is %h", commit.pc);

endmodule

bind rv_core rv_core_properties i_rv_core_properties (
  .clk(clk),
  .reset(reset),
  .retire(retire),
  .commit(commit)
);

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter int imem_words = 64,
  parameter int dmem_words = 32
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          load_en,
  input  logic [$clog2(imem_words)-1:0] load_addr,
  input  logic [rv_pkg::xlen-1:0]       load_data,
  output logic                          retire,
  output rv_pkg::commit_t               commit
);

  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  rv_pkg::instr_t          instr;
  rv_pkg::ctrl_t           ctrl;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] alu_b;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic                    eq;
  logic [rv_pkg::xlen-1:0] wb_data;

  fetch_unit #(
    .imem_words(imem_words)
  ) fetch_unit_inst (
    .clk(clk),
    .reset(reset),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .pc_sel(ctrl.pc_sel),
    .imm(ctrl.imm),
    .alu_result(alu_result),
    .eq(eq),
    .pc(pc),
    .pc_plus4(pc_plus4),
    .instr(instr)
  );

  decoder decoder_inst (
    .instr(instr),
    .ctrl(ctrl)
  );

  register_file register_file_inst (
    .clk(clk),
    .reset(reset),
    .rs1(ctrl.rs1),
    .rs2(ctrl.rs2),
    .rd(ctrl.rd),
    .we(ctrl.reg_we),
    .wd(wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  // second operand, immediate or rs2
  assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  alu alu_inst (
    .a(rs1_data),
    .b(alu_b),
    .op(ctrl.alu_op),
    .result(alu_result),
    .eq(eq)
  );

  load_store_unit #(
    .dmem_words(dmem_words)
  ) load_store_unit_inst (
    .clk(clk),
    .reset(reset),
    .addr(alu_result),
    .st_data(rs2_data),
    .we(ctrl.mem_we),
    .wb_sel(ctrl.wb_sel),
    .alu_result(alu_result),
    .pc_plus4(pc_plus4),
    .imm(ctrl.imm),
    .wb_data(wb_data)
  );

  // never stalls, so one retire per cycle once out of reset
  assign retire = ~reset;

  always_comb begin
    commit.pc      = pc;
    commit.instr   = instr;
    commit.rd_we   = ctrl.reg_we && (ctrl.rd != 5'd0);
    commit.rd      = ctrl.rd;
    commit.rd_data = wb_data;
    commit.st_we   = ctrl.mem_we;
    commit.st_addr = alu_result;
    commit.st_data = rs2_data;
  end

endmodule

/* source/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit #(
  parameter int dmem_words = 32
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [rv_pkg::xlen-1:0] addr,
  input  logic [rv_pkg::xlen-1:0] st_data,
  input  logic                    we,
  input  rv_pkg::wb_sel_e         wb_sel,
  input  logic [rv_pkg::xlen-1:0] alu_result,
  input  logic [rv_pkg::xlen-1:0] pc_plus4,
  input  logic [rv_pkg::xlen-1:0] imm,
  output logic [rv_pkg::xlen-1:0] wb_data
);

  localparam int daw = $clog2(dmem_words);

  logic [rv_pkg::xlen-1:0] dmem [dmem_words];
  logic [rv_pkg::xlen-1:0] ld_word;
  logic [daw-1:0]          idx;

  // word index, wraps modulo the memory size
  assign idx = addr[daw+1:2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] <= '0;
      end
    end else if (we) begin
      dmem[idx] <= st_data;
    end
  end

  assign ld_word = dmem[idx];

  always_comb begin
    case (wb_sel)
      rv_pkg::wb_mem: wb_data = ld_word;
      rv_pkg::wb_pc4: wb_data = pc_plus4;
      // lui writes the shifted immediate
      rv_pkg::wb_imm: wb_data = imm;
      default:        wb_data = alu_result;
    endcase
  end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_e         op,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    eq
);

  logic [4:0] sh;

  // shifts use the low five bits only
  assign sh = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::alu_add: result = a + b;
      rv_pkg::alu_sub: result = a - b;
      rv_pkg::alu_and: result = a & b;
      rv_pkg::alu_or:  result = a | b;
      rv_pkg::alu_xor: result = a ^ b;
      rv_pkg::alu_sll: result = a << sh;
      rv_pkg::alu_srl: result = a >> sh;
      rv_pkg::alu_sra: result = $unsigned($signed(a) >>> sh);
      rv_pkg::alu_slt: result = {{(rv_pkg::xlen-1){1'b0}}, ($signed(a) < $signed(b))};
      default:         result = a + b;
    endcase
  end

  // branch compare
  assign eq = (a == b);

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [4:0]              rs1,
  input  logic [4:0]              rs2,
  input  logic [4:0]              rd,
  input  logic                    we,
  input  logic [rv_pkg::xlen-1:0] wd,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);

  logic [rv_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != 5'd0)) begin
      regs[rd] <= wd;
    end
  end

  // x0 is hardwired, no bypass from the write port
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder (
  input  rv_pkg::instr_t instr,
  output rv_pkg::ctrl_t  ctrl
);

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;
  logic [rv_pkg::xlen-1:0] shamt;

  assign imm_i = {{(rv_pkg::xlen-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
  assign imm_s = {{(rv_pkg::xlen-12){instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
  assign imm_b = {{(rv_pkg::xlen-13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                  instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
  assign imm_u = {instr.u.imm_31_12, 12'b0};
  assign imm_j = {{(rv_pkg::xlen-21){instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                  instr.j.imm_11, instr.j.imm_10_1, 1'b0};
  // shift immediates carry the amount in the rs2 slot
  assign shamt = {{(rv_pkg::xlen-5){1'b0}}, instr.r.rs2};

  always_comb begin
    ctrl        = '0;
    ctrl.rs1    = instr.r.rs1;
    ctrl.rs2    = instr.r.rs2;
    ctrl.rd     = instr.r.rd;
    ctrl.alu_op = rv_pkg::alu_add;
    ctrl.wb_sel = rv_pkg::wb_alu;
    ctrl.pc_sel = rv_pkg::pc_seq;
    case (instr.r.opcode)
      rv_pkg::opc_op: begin
        ctrl.reg_we = 1'b1;
        case ({instr.r.funct7, instr.r.funct3})
          {f7_base, 3'b000}: ctrl.alu_op = rv_pkg::alu_add;
          {f7_alt, 3'b000}:  ctrl.alu_op = rv_pkg::alu_sub;
          {f7_base, 3'b001}: ctrl.alu_op = rv_pkg::alu_sll;
          {f7_base, 3'b010}: ctrl.alu_op = rv_pkg::alu_slt;
          {f7_base, 3'b100}: ctrl.alu_op = rv_pkg::alu_xor;
          {f7_base, 3'b101}: ctrl.alu_op = rv_pkg::alu_srl;
          {f7_alt, 3'b101}:  ctrl.alu_op = rv_pkg::alu_sra;
          {f7_base, 3'b110}: ctrl.alu_op = rv_pkg::alu_or;
          {f7_base, 3'b111}: ctrl.alu_op = rv_pkg::alu_and;
          default:           ctrl.reg_we = 1'b0;
        endcase
      end
      rv_pkg::opc_op_imm: begin
        ctrl.reg_we  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_i;
        case (instr.i.funct3)
          3'b000: ctrl.alu_op = rv_pkg::alu_add;
          3'b100: ctrl.alu_op = rv_pkg::alu_xor;
          3'b110: ctrl.alu_op = rv_pkg::alu_or;
          3'b111: ctrl.alu_op = rv_pkg::alu_and;
          3'b001: begin
            ctrl.imm    = shamt;
            ctrl.alu_op = rv_pkg::alu_sll;
            ctrl.reg_we = (instr.r.funct7 == f7_base);
          end
          3'b101: begin
            ctrl.imm = shamt;
            if (instr.r.funct7 == f7_alt) begin
              ctrl.alu_op = rv_pkg::alu_sra;
            end else begin
              ctrl.alu_op = rv_pkg::alu_srl;
            end
            ctrl.reg_we = (instr.r.funct7 == f7_base) || (instr.r.funct7 == f7_alt);
          end
          default: ctrl.reg_we = 1'b0;
        endcase
      end
      rv_pkg::opc_lui: begin
        ctrl.reg_we = 1'b1;
        ctrl.imm    = imm_u;
        ctrl.wb_sel = rv_pkg::wb_imm;
      end
      rv_pkg::opc_load: begin
        // word access only
        ctrl.reg_we  = (instr.i.funct3 == 3'b010);
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_i;
        ctrl.wb_sel  = rv_pkg::wb_mem;
      end
      rv_pkg::opc_store: begin
        ctrl.mem_we  = (instr.s.funct3 == 3'b010);
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_s;
      end
      rv_pkg::opc_jal: begin
        ctrl.reg_we = 1'b1;
        ctrl.imm    = imm_j;
        ctrl.wb_sel = rv_pkg::wb_pc4;
        ctrl.pc_sel = rv_pkg::pc_jal;
      end
      rv_pkg::opc_jalr: begin
        if (instr.i.funct3 == 3'b000) begin
          ctrl.reg_we  = 1'b1;
          ctrl.use_imm = 1'b1;
          ctrl.imm     = imm_i;
          ctrl.wb_sel  = rv_pkg::wb_pc4;
          ctrl.pc_sel  = rv_pkg::pc_jalr;
        end
      end
      rv_pkg::opc_branch: begin
        ctrl.imm    = imm_b;
        ctrl.alu_op = rv_pkg::alu_sub;
        case (instr.b.funct3)
          3'b000:  ctrl.pc_sel = rv_pkg::pc_beq;
          3'b001:  ctrl.pc_sel = rv_pkg::pc_bne;
          default: ctrl.pc_sel = rv_pkg::pc_seq;
        endcase
      end
      default: ctrl.reg_we = 1'b0;
    endcase
  end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
  parameter int imem_words = 64
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          load_en,
  input  logic [$clog2(imem_words)-1:0] load_addr,
  input  logic [rv_pkg::xlen-1:0]       load_data,
  input  rv_pkg::pc_sel_e               pc_sel,
  input  logic [rv_pkg::xlen-1:0]       imm,
  input  logic [rv_pkg::xlen-1:0]       alu_result,
  input  logic                          eq,
  output logic [rv_pkg::xlen-1:0]       pc,
  output logic [rv_pkg::xlen-1:0]       pc_plus4,
  output rv_pkg::instr_t                instr
);

  localparam int iaw = $clog2(imem_words);

  logic [rv_pkg::xlen-1:0] imem [imem_words];
  logic [rv_pkg::xlen-1:0] target;
  logic [rv_pkg::xlen-1:0] next_pc;

  // program load, works in and out of reset
  always_ff @(posedge clk) begin
    if (load_en) begin
      imem[load_addr] <= load_data;
    end
  end

  // word index wraps modulo the array size
  assign instr = imem[pc[iaw+1:2]];

  assign pc_plus4 = pc + 32'd4;
  assign target   = pc + imm;

  always_comb begin
    case (pc_sel)
      rv_pkg::pc_jal:  next_pc = target;
      rv_pkg::pc_jalr: next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
      rv_pkg::pc_beq:  next_pc = eq ? target : pc_plus4;
      rv_pkg::pc_bne:  next_pc = eq ? pc_plus4 : target;
      default:         next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

  parameter int xlen = 32;

  // major opcodes of the kept instructions
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt
  } alu_op_e;

  typedef enum logic [2:0] {
    pc_seq,
    pc_jal,
    pc_jalr,
    pc_beq,
    pc_bne
  } pc_sel_e;

  // writeback source
  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc4,
    wb_imm
  } wb_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_type_t;

  // one fetched word, read through the view its opcode selects
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_t;

  typedef struct packed {
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    logic            use_imm;
    logic            reg_we;
    logic            mem_we;
    wb_sel_e         wb_sel;
    pc_sel_e         pc_sel;
  } ctrl_t;

  // one retired instruction
  typedef struct packed {
    logic [xlen-1:0] pc;
    instr_t          instr;
    logic            rd_we;
    logic [4:0]      rd;
    logic [xlen-1:0] rd_data;
    logic            st_we;
    logic [xlen-1:0] st_addr;
    logic [xlen-1:0] st_data;
  } commit_t;

endpackage
